// File: common/extbus_pkg.sv
package extbus_pkg;

    ////////////////////////////////
    // CPU register map
    ////////////////////////////////

    typedef enum logic [2:0] {
        reg_addr_hi  = 3'd0,
        reg_addr_mid = 3'd1,
        reg_addr_lo  = 3'd2,
        reg_data0    = 3'd3,
        reg_data1    = 3'd4,
        reg_ctrl     = 3'd5,
        reg_ien      = 3'd6,
        reg_isr      = 3'd7
    } ext_reg_e;

    // One CPU bus event as seen in the bm_clk domain
    typedef struct packed {
        logic       access_start;
        logic       access_end;
        ext_reg_e   addr;
        logic       rw_n;
        logic [7:0] wdata;
        logic       selected;
        logic       deselect;
    } ext_event_t;

    // Synchronizer depth and age of the captured bus values
    localparam int SYNC_STAGES   = 2;
    localparam int CAPTURE_DELAY = 3;

    ////////////////////////////////
    // Read view layout
    ////////////////////////////////

    localparam int         HI_INCR_LSB       = 4;
    localparam int         ADDR_HI_BITS      = 3;
    localparam int         CTRL_WARMBOOT_BIT = 7;
    localparam int         CTRL_PSEL_BIT     = 0;
    localparam logic [7:0] RD_UNUSED         = 8'h00;

endpackage

// File: common/bm_pkg.sv
package bm_pkg;

    ////////////////////////////////
    // Bus master sizes
    ////////////////////////////////

    // 512 KB of byte-wide video memory
    localparam int BM_ADDR_W = 19;

    // Auto-increment step per data-window access
    localparam int INCR_W = 4;

    // Interrupt sources, one status bit each
    localparam int NUM_IRQ = 8;

    typedef logic [BM_ADDR_W-1:0] bm_addr_t;

    ////////////////////////////////
    // Memory request
    ////////////////////////////////

    // Single-cycle strobe; read data follows one cycle later
    typedef struct packed {
        logic       strobe;
        logic       write;
        bm_addr_t   addr;
        logic [7:0] wdata;
    } bm_req_t;

endpackage

// File: extbus/extbus_phy.sv
module extbus_phy
    import extbus_pkg::*;
(
    input  logic       bm_clk,
    input  logic       bm_reset,
    input  logic       extbus_phy2,
    input  logic       extbus_cs_n,
    input  logic       extbus_rw_n,
    input  logic [2:0] extbus_a,
    inout  wire  [7:0] extbus_d,
    output wire        extbus_rdy,
    output wire        extbus_irq_n,
    input  logic [7:0] rd_data,
    input  logic       busy,
    input  logic       irq,
    output ext_event_t ev
);

    // Bus values that are sampled together
    typedef struct packed {
        ext_reg_e   addr;
        logic       rw_n;
        logic [7:0] wdata;
    } capture_t;

    logic                   access_raw;
    logic [SYNC_STAGES-1:0] cs_sync;
    logic [SYNC_STAGES-1:0] access_sync;
    logic                   cs_level;
    logic                   access_level;
    logic                   cs_prev;
    logic                   access_prev;
    capture_t               live;
    capture_t               hist [CAPTURE_DELAY];

    ////////////////////////////////
    // Pad drivers
    ////////////////////////////////

    // Drive read data only for a selected read cycle
    assign extbus_d = (!extbus_cs_n && extbus_rw_n) ? rd_data : 8'hzz;

    // Open-drain outputs are released when inactive
    assign extbus_rdy   = (!extbus_cs_n && busy) ? 1'b0 : 1'bz;
    assign extbus_irq_n = irq ? 1'b0 : 1'bz;

    ////////////////////////////////
    // Synchronizers
    ////////////////////////////////

    assign access_raw = extbus_phy2 && !extbus_cs_n;

    always_ff @(posedge bm_clk or posedge bm_reset) begin
        if (bm_reset) begin
            cs_sync     <= '0;
            access_sync <= '0;
            cs_prev     <= 1'b0;
            access_prev <= 1'b0;
        end else begin
            cs_sync     <= {cs_sync[SYNC_STAGES-2:0], !extbus_cs_n};
            access_sync <= {access_sync[SYNC_STAGES-2:0], access_raw};
            cs_prev     <= cs_level;
            access_prev <= access_level;
        end
    end

    assign cs_level     = cs_sync[SYNC_STAGES-1];
    assign access_level = access_sync[SYNC_STAGES-1];

    // History of bus values while the access is high
    assign live = capture_t'{addr: ext_reg_e'(extbus_a), rw_n: extbus_rw_n, wdata: extbus_d};

    always_ff @(posedge bm_clk) begin
        if (access_level) begin
            hist[0] <= live;
            for (int i = 1; i < CAPTURE_DELAY; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    ////////////////////////////////
    // Event output
    ////////////////////////////////

    always_comb begin
        ev.access_start = access_level && !access_prev;
        ev.access_end   = !access_level && access_prev;
        // End event uses values from before phy2 fell
        ev.addr         = ev.access_end ? hist[CAPTURE_DELAY-1].addr : live.addr;
        ev.rw_n         = ev.access_end ? hist[CAPTURE_DELAY-1].rw_n : live.rw_n;
        ev.wdata        = hist[CAPTURE_DELAY-1].wdata;
        ev.selected     = cs_level;
        ev.deselect     = !cs_level && cs_prev;
    end

    // Access edges are at least two cycles apart
    start_end_exclusive: assert property (
        @(posedge bm_clk) disable iff (bm_reset)
        (ev.access_start || ev.access_end) |=> !(ev.access_start || ev.access_end)
    );

endmodule

// File: rtl/port_regs.sv
module port_regs
    import extbus_pkg::*;
    import bm_pkg::*;
(
    input  logic               bm_clk,
    input  logic               bm_reset,
    input  ext_event_t         ev,
    input  logic [NUM_IRQ-1:0] irqs,
    input  logic [7:0]         mem_rdata,
    output logic [7:0]         rd_data,
    output logic               busy,
    output logic               irq,
    output logic               warmboot,
    output bm_req_t            req
);

    bm_addr_t           addr_q [2];
    bm_addr_t           addr_d [2];
    logic [INCR_W-1:0]  incr_q [2];
    logic [INCR_W-1:0]  incr_d [2];
    logic               psel_q;
    logic               psel_d;
    logic               warmboot_q;
    logic               warmboot_d;
    logic [NUM_IRQ-1:0] ien_q;
    logic [NUM_IRQ-1:0] ien_d;
    logic [NUM_IRQ-1:0] isr_q;
    logic [NUM_IRQ-1:0] isr_d;
    logic [NUM_IRQ-1:0] isr_clr;
    logic [7:0]         rbuf_q;
    logic [7:0]         rbuf_d;
    logic               busy_q;
    logic               busy_d;
    logic               rd_pending_q;
    bm_req_t            req_q;
    bm_req_t            req_d;
    logic               do_access;
    logic               access_port;

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        addr_d      = addr_q;
        incr_d      = incr_q;
        psel_d      = psel_q;
        warmboot_d  = warmboot_q;
        ien_d       = ien_q;
        rbuf_d      = rbuf_q;
        busy_d      = busy_q;
        isr_clr     = '0;
        req_d       = req_q;
        req_d.strobe = 1'b0;
        req_d.write  = 1'b0;
        do_access   = 1'b0;
        access_port = 1'b0;

        // Memory byte is back, release the CPU
        if (rd_pending_q) begin
            rbuf_d = mem_rdata;
            busy_d = 1'b0;
        end

        // Every new CPU cycle starts out stalled
        if (ev.deselect) begin
            busy_d = 1'b1;
        end

        // Data-window reads go out as early as possible
        if (ev.access_start && ev.selected) begin
            if (ev.rw_n && (ev.addr == reg_data0 || ev.addr == reg_data1)) begin
                do_access   = 1'b1;
                access_port = (ev.addr == reg_data1);
            end else begin
                busy_d = 1'b0;
            end
        end

        if (ev.access_end && !ev.rw_n) begin
            case (ev.addr)
                reg_addr_hi: begin
                    incr_d[psel_q] = ev.wdata[HI_INCR_LSB +: INCR_W];
                    addr_d[psel_q][16 +: ADDR_HI_BITS] = ev.wdata[ADDR_HI_BITS-1:0];
                end
                reg_addr_mid: begin
                    addr_d[psel_q][15:8] = ev.wdata;
                end
                reg_addr_lo: begin
                    addr_d[psel_q][7:0] = ev.wdata;
                end
                reg_data0, reg_data1: begin
                    do_access    = 1'b1;
                    access_port  = (ev.addr == reg_data1);
                    req_d.write  = 1'b1;
                    req_d.wdata  = ev.wdata;
                end
                reg_ctrl: begin
                    warmboot_d = ev.wdata[CTRL_WARMBOOT_BIT];
                    psel_d     = ev.wdata[CTRL_PSEL_BIT];
                end
                reg_ien: begin
                    ien_d = ev.wdata;
                end
                reg_isr: begin
                    isr_clr = ev.wdata;
                end
                default: ;
            endcase
        end

        // Clear written ones first, active sources still set their bit
        isr_d = (isr_q & ~isr_clr) | irqs;

        // Strobe and post-increment of the addressed port
        if (do_access) begin
            req_d.strobe = 1'b1;
            req_d.addr   = addr_q[access_port];
            addr_d[access_port] = addr_q[access_port]
                                + {{(BM_ADDR_W-INCR_W){1'b0}}, incr_q[access_port]};
        end
    end

    always_ff @(posedge bm_clk or posedge bm_reset) begin
        if (bm_reset) begin
            addr_q       <= '{default: '0};
            incr_q       <= '{default: '0};
            psel_q       <= 1'b0;
            warmboot_q   <= 1'b0;
            ien_q        <= '0;
            isr_q        <= '0;
            rbuf_q       <= '0;
            busy_q       <= 1'b0;
            rd_pending_q <= 1'b0;
            req_q        <= '0;
        end else begin
            addr_q       <= addr_d;
            incr_q       <= incr_d;
            psel_q       <= psel_d;
            warmboot_q   <= warmboot_d;
            ien_q        <= ien_d;
            isr_q        <= isr_d;
            rbuf_q       <= rbuf_d;
            busy_q       <= busy_d;
            rd_pending_q <= req_q.strobe && !req_q.write;
            req_q        <= req_d;
        end
    end

    //////////////////////////////
    // Read view
    //////////////////////////////

    always_comb begin
        rd_data = RD_UNUSED;
        case (ev.addr)
            reg_addr_hi: begin
                rd_data[HI_INCR_LSB +: INCR_W]   = incr_q[psel_q];
                rd_data[ADDR_HI_BITS-1:0]        = addr_q[psel_q][16 +: ADDR_HI_BITS];
            end
            reg_addr_mid:         rd_data = addr_q[psel_q][15:8];
            reg_addr_lo:          rd_data = addr_q[psel_q][7:0];
            reg_data0, reg_data1: rd_data = rbuf_q;
            reg_ctrl: begin
                rd_data[CTRL_WARMBOOT_BIT] = warmboot_q;
                rd_data[CTRL_PSEL_BIT]     = psel_q;
            end
            reg_ien:              rd_data = ien_q;
            reg_isr:              rd_data = isr_q;
            default:              rd_data = RD_UNUSED;
        endcase
    end

    assign busy     = busy_q;
    assign irq      = |(isr_q & ien_q);
    assign warmboot = warmboot_q;
    assign req      = req_q;

    strobe_single_cycle: assert property (
        @(posedge bm_clk) disable iff (bm_reset)
        req_q.strobe |=> !req_q.strobe
    );

    // Writes only commit once the CPU cycle has ended
    write_after_end: assert property (
        @(posedge bm_clk) disable iff (bm_reset)
        (req_q.strobe && req_q.write) |-> $past(ev.access_end && !ev.rw_n)
    );

endmodule

// File: rtl/vram_sram.sv
module vram_sram
    import bm_pkg::*;
(
    input  logic       bm_clk,
    input  bm_req_t    req,
    output logic [7:0] rd_data
);

    ////////////////////////////////
    // Byte array
    ////////////////////////////////

    logic [7:0] mem [2**BM_ADDR_W];

    // Synchronous port, read data one cycle after the strobe
    always_ff @(posedge bm_clk) begin
        if (req.strobe) begin
            if (req.write) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rd_data <= mem[req.addr];
            end
        end
    end

    addr_known: assert property (
        @(posedge bm_clk)
        req.strobe |-> !$isunknown(req.addr)
    );

endmodule

// File: rtl/extbus_bridge_top.sv
module extbus_bridge_top
    import extbus_pkg::*;
    import bm_pkg::*;
(
    input  logic               bm_clk,
    input  logic               bm_reset,
    input  logic               extbus_phy2,
    input  logic               extbus_cs_n,
    input  logic               extbus_rw_n,
    input  logic [2:0]         extbus_a,
    inout  wire  [7:0]         extbus_d,
    output wire                extbus_rdy,
    output wire                extbus_irq_n,
    input  logic [NUM_IRQ-1:0] irqs,
    output logic               warmboot
);

    ext_event_t ev;
    logic [7:0] view_data;
    logic       busy;
    logic       irq;
    bm_req_t    req;
    logic [7:0] mem_rdata;

    // CPU bus side
    extbus_phy u_phy (
        .bm_clk       (bm_clk),
        .bm_reset     (bm_reset),
        .extbus_phy2  (extbus_phy2),
        .extbus_cs_n  (extbus_cs_n),
        .extbus_rw_n  (extbus_rw_n),
        .extbus_a     (extbus_a),
        .extbus_d     (extbus_d),
        .extbus_rdy   (extbus_rdy),
        .extbus_irq_n (extbus_irq_n),
        .rd_data      (view_data),
        .busy         (busy),
        .irq          (irq),
        .ev           (ev)
    );

    // Registers and memory master
    port_regs u_regs (
        .bm_clk    (bm_clk),
        .bm_reset  (bm_reset),
        .ev        (ev),
        .irqs      (irqs),
        .mem_rdata (mem_rdata),
        .rd_data   (view_data),
        .busy      (busy),
        .irq       (irq),
        .warmboot  (warmboot),
        .req       (req)
    );

    vram_sram u_vram (
        .bm_clk  (bm_clk),
        .req     (req),
        .rd_data (mem_rdata)
    );

endmodule

// File: test/cpu_bus_tasks.svh
`ifndef CPU_BUS_TASKS_SVH
`define CPU_BUS_TASKS_SVH

//////////////////////////////
// 6502 bus cycles
//////////////////////////////

// One CPU cycle is 2 low, 10 high and 4 low bm_clk periods of phy2
// Chip select stays high in the tail so the deselect is seen
task automatic bus_cycle(
    input  ext_reg_e   r,
    input  logic       rw_n,
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    output logic       rdy_first,
    output logic       rdy_last
);
    // Address phase with phy2 low
    @(posedge bm_clk);
    extbus_cs_n <= 1'b0;
    extbus_a    <= r;
    extbus_rw_n <= rw_n;
    d_drive     <= wdata;
    d_drive_en  <= !rw_n;
    @(negedge bm_clk);
    rdy_first = extbus_rdy;
    @(posedge bm_clk);
    @(posedge bm_clk);
    extbus_phy2 <= 1'b1;
    repeat (PHY2_HIGH_CYCLES - 1) @(posedge bm_clk);
    // Last cycle before phy2 falls
    @(negedge bm_clk);
    rdata    = extbus_d;
    rdy_last = extbus_rdy;
    @(posedge bm_clk);
    extbus_phy2 <= 1'b0;
    extbus_cs_n <= 1'b1;
    d_drive_en  <= 1'b0;
    repeat (3) @(posedge bm_clk);
endtask

task automatic cpu_write(input ext_reg_e r, input logic [7:0] wdata);
    logic [7:0] rdata;
    logic       rdy_first;
    logic       rdy_last;
    bus_cycle(r, 1'b0, wdata, rdata, rdy_first, rdy_last);
endtask

task automatic cpu_read(
    input  ext_reg_e   r,
    output logic [7:0] rdata,
    output logic       rdy_first,
    output logic       rdy_last
);
    bus_cycle(r, 1'b1, 8'h00, rdata, rdy_first, rdy_last);
endtask

`endif

// File: test/tb_extbus_bridge.sv
module tb_extbus_bridge
    import extbus_pkg::*;
    import bm_pkg::*;
();

    localparam int PHY2_HIGH_CYCLES = 10;
    localparam int CPU_CYCLE_LEN    = 16;
    localparam int MAX_CPU_CYCLES   = 400;
    localparam int TIMEOUT_CYCLES   = MAX_CPU_CYCLES * CPU_CYCLE_LEN + 500;
    localparam int WINDOW_ACCESSES  = 12;
    localparam int ADDR_ROUNDS      = 6;
    localparam int IRQ_ROUNDS       = 8;

    logic               bm_clk;
    logic               bm_reset;
    logic               extbus_phy2;
    logic               extbus_cs_n;
    logic               extbus_rw_n;
    logic [2:0]         extbus_a;
    wire  [7:0]         extbus_d;
    tri1                extbus_rdy;
    tri1                extbus_irq_n;
    logic [NUM_IRQ-1:0] irqs;
    logic               warmboot;
    logic [7:0]         d_drive;
    logic               d_drive_en;

    // Reference model state
    bm_addr_t           m_addr [2];
    logic [INCR_W-1:0]  m_incr [2];
    logic               m_psel;
    logic               m_warm;
    logic [7:0]         m_ien;
    logic [7:0]         m_isr;
    logic [7:0]         mem_model [int];

    integer             seed;
    int                 cycle_count;

    assign extbus_d = d_drive_en ? d_drive : 8'hzz;

    extbus_bridge_top dut0 (
        .bm_clk       (bm_clk),
        .bm_reset     (bm_reset),
        .extbus_phy2  (extbus_phy2),
        .extbus_cs_n  (extbus_cs_n),
        .extbus_rw_n  (extbus_rw_n),
        .extbus_a     (extbus_a),
        .extbus_d     (extbus_d),
        .extbus_rdy   (extbus_rdy),
        .extbus_irq_n (extbus_irq_n),
        .irqs         (irqs),
        .warmboot     (warmboot)
    );

    `include "cpu_bus_tasks.svh"

    initial begin
        bm_clk = 1'b0;
        forever #5 bm_clk = ~bm_clk;
    end

    always @(posedge bm_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
            report_failure();
        end
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic report_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%02h, expected 0x%02h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_reg(input ext_reg_e r, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%02h, expected 0x%02h", r.name(), got, exp);
            report_failure();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%01h, expected 0x%01h", name, got, exp);
            report_failure();
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [7:0] expected_reg(input ext_reg_e r);
        logic [7:0] v;
        v = 8'h00;
        case (r)
            reg_addr_hi:  v = {m_incr[m_psel], 1'b0, m_addr[m_psel][18:16]};
            reg_addr_mid: v = m_addr[m_psel][15:8];
            reg_addr_lo:  v = m_addr[m_psel][7:0];
            reg_ctrl:     v = {m_warm, 6'b0, m_psel};
            reg_ien:      v = m_ien;
            reg_isr:      v = m_isr;
            default:      v = 8'h00;
        endcase
        return v;
    endfunction

    task automatic model_reg_write(input ext_reg_e r, input logic [7:0] w);
        case (r)
            reg_addr_hi: begin
                m_incr[m_psel]         = w[7:4];
                m_addr[m_psel][18:16] = w[2:0];
            end
            reg_addr_mid: m_addr[m_psel][15:8] = w;
            reg_addr_lo:  m_addr[m_psel][7:0]  = w;
            reg_ctrl: begin
                m_warm = w[7];
                m_psel = w[0];
            end
            reg_ien: m_ien = w;
            // Sources still active keep their bit
            reg_isr: m_isr = (m_isr & ~w) | irqs;
            default: ;
        endcase
    endtask

    task automatic reg_write(input ext_reg_e r, input logic [7:0] w);
        cpu_write(r, w);
        model_reg_write(r, w);
    endtask

    task automatic read_and_check_reg(input ext_reg_e r);
        logic [7:0] rdata;
        logic       rdy_first;
        logic       rdy_last;
        cpu_read(r, rdata, rdy_first, rdy_last);
        check_reg(r, rdata, expected_reg(r));
        check_level("extbus_rdy before phy2 falls", rdy_last, 1'b1);
    endtask

    task automatic check_port_regs(input logic p);
        reg_write(reg_ctrl, {7'b0, p});
        read_and_check_reg(reg_addr_hi);
        read_and_check_reg(reg_addr_mid);
        read_and_check_reg(reg_addr_lo);
    endtask

    task automatic load_port(input logic p, input bm_addr_t addr, input logic [INCR_W-1:0] incr);
        reg_write(reg_ctrl, {7'b0, p});
        reg_write(reg_addr_hi, {incr, 1'b0, addr[18:16]});
        reg_write(reg_addr_mid, addr[15:8]);
        reg_write(reg_addr_lo, addr[7:0]);
    endtask

    task automatic window_write(input logic p, input logic [7:0] w);
        cpu_write(p ? reg_data1 : reg_data0, w);
        mem_model[int'(m_addr[p])] = w;
        m_addr[p] = m_addr[p] + m_incr[p];
    endtask

    task automatic window_read(input logic p);
        logic [7:0] rdata;
        logic       rdy_first;
        logic       rdy_last;
        int         key;
        key = int'(m_addr[p]);
        cpu_read(p ? reg_data1 : reg_data0, rdata, rdy_first, rdy_last);
        if (!mem_model.exists(key)) begin
            $display("Window %0d read an address that was never written", p);
            report_failure();
        end
        check_byte("extbus_d", rdata, mem_model[key]);
        // Stalled since the previous deselect
        check_level("extbus_rdy at access start", rdy_first, 1'b0);
        check_level("extbus_rdy before phy2 falls", rdy_last, 1'b1);
        m_addr[p] = m_addr[p] + m_incr[p];
    endtask

    task automatic set_irqs(input logic [NUM_IRQ-1:0] v);
        @(posedge bm_clk);
        irqs <= v;
        m_isr = m_isr | v;
    endtask

    task automatic check_irq_line();
        @(negedge bm_clk);
        check_level("extbus_irq_n", extbus_irq_n, ~|(m_isr & m_ien));
    endtask

    //////////////////////////////
    // Scenarios
    //////////////////////////////

    task automatic test_reset_values();
        @(negedge bm_clk);
        check_level("extbus_irq_n", extbus_irq_n, 1'b1);
        check_level("extbus_rdy", extbus_rdy, 1'b1);
        check_level("warmboot", warmboot, 1'b0);
        read_and_check_reg(reg_addr_hi);
        read_and_check_reg(reg_addr_mid);
        read_and_check_reg(reg_addr_lo);
        read_and_check_reg(reg_ctrl);
        read_and_check_reg(reg_ien);
        read_and_check_reg(reg_isr);
        check_port_regs(1'b1);
    endtask

    task automatic test_addr_regs();
        logic [31:0] rnd;
        logic        p;
        for (int i = 0; i < ADDR_ROUNDS; i++) begin
            rnd = $random(seed);
            p   = rnd[0];
            reg_write(reg_ctrl, {7'b0, p});
            reg_write(reg_addr_hi, rnd[15:8]);
            reg_write(reg_addr_mid, rnd[23:16]);
            reg_write(reg_addr_lo, rnd[31:24]);
            read_and_check_reg(reg_addr_hi);
            read_and_check_reg(reg_addr_mid);
            read_and_check_reg(reg_addr_lo);
            // Other port must be untouched
            check_port_regs(!p);
        end
    endtask

    task automatic test_windows(input int round);
        bm_addr_t          start [2];
        logic [INCR_W-1:0] step [2];
        logic              port_seq [WINDOW_ACCESSES];
        logic [31:0]       rnd;
        for (int p = 0; p < 2; p++) begin
            rnd      = $random(seed);
            start[p] = rnd[BM_ADDR_W-1:0];
            step[p]  = rnd[31:28];
        end
        if (round == 0) begin
            // Port 1 stays on one byte
            step[1] = '0;
        end else begin
            // Port 0 walks across the top of memory
            start[0] = 19'h7fff8;
            if (step[0] == '0) begin
                step[0] = 4'd1;
            end
        end
        for (int p = 0; p < 2; p++) begin
            load_port(1'(p), start[p], step[p]);
        end
        for (int i = 0; i < WINDOW_ACCESSES; i++) begin
            rnd         = $random(seed);
            port_seq[i] = rnd[0];
            window_write(port_seq[i], rnd[15:8]);
        end
        check_port_regs(1'b0);
        check_port_regs(1'b1);
        // Rewind and read back in the same port order
        for (int p = 0; p < 2; p++) begin
            load_port(1'(p), start[p], step[p]);
        end
        for (int i = 0; i < WINDOW_ACCESSES; i++) begin
            window_read(port_seq[i]);
        end
        check_port_regs(1'b0);
        check_port_regs(1'b1);
    endtask

    task automatic test_irq();
        logic [31:0] rnd;
        logic [31:0] rnd_clr;
        reg_write(reg_isr, 8'hff);
        for (int i = 0; i < IRQ_ROUNDS; i++) begin
            rnd = $random(seed);
            reg_write(reg_ien, rnd[7:0]);
            check_irq_line();
            set_irqs(rnd[15:8]);
            set_irqs('0);
            check_irq_line();
            read_and_check_reg(reg_isr);
            // Some cleared sources are still held active
            rnd_clr = $random(seed);
            set_irqs(rnd_clr[15:8] & rnd_clr[23:16]);
            reg_write(reg_isr, rnd_clr[15:8]);
            set_irqs('0);
            check_irq_line();
            read_and_check_reg(reg_isr);
        end
    endtask

    task automatic test_warmboot();
        reg_write(reg_ctrl, 8'h81);
        @(negedge bm_clk);
        check_level("warmboot", warmboot, 1'b1);
        read_and_check_reg(reg_ctrl);
        read_and_check_reg(reg_addr_lo);
        reg_write(reg_ctrl, 8'h80);
        read_and_check_reg(reg_ctrl);
        reg_write(reg_ctrl, 8'h00);
        @(negedge bm_clk);
        check_level("warmboot", warmboot, 1'b0);
    endtask

    initial begin
        bm_reset    = 1'b1;
        extbus_phy2 = 1'b0;
        extbus_cs_n = 1'b1;
        extbus_rw_n = 1'b1;
        extbus_a    = 3'd0;
        irqs        = '0;
        d_drive     = 8'h00;
        d_drive_en  = 1'b0;
        m_addr      = '{default: '0};
        m_incr      = '{default: '0};
        m_psel      = 1'b0;
        m_warm      = 1'b0;
        m_ien       = 8'h00;
        m_isr       = 8'h00;
        seed        = 32'he4bd_093c;
        cycle_count = 0;
        repeat (4) @(posedge bm_clk);
        bm_reset <= 1'b0;
        repeat (2) @(posedge bm_clk);
        test_reset_values();
        test_addr_regs();
        test_windows(0);
        test_windows(1);
        test_irq();
        test_warmboot();
        repeat (4) @(posedge bm_clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: project.f
+incdir+test
common/extbus_pkg.sv
common/bm_pkg.sv
extbus/extbus_phy.sv
rtl/port_regs.sv
rtl/vram_sram.sv
rtl/extbus_bridge_top.sv
test/tb_extbus_bridge.sv

// File: Bender.yml
package:
  name: extbus_bridge

sources:
  - common/extbus_pkg.sv
  - common/bm_pkg.sv
  - extbus/extbus_phy.sv
  - rtl/port_regs.sv
  - rtl/vram_sram.sv
  - rtl/extbus_bridge_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_extbus_bridge.sv
